// ==== Makefile ====
# Verilator flow for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
rtl/rv_decode_pkg.sv
rtl/instruction_decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/decode_stage.sv
tests/tb_clock.sv
tests/tb_decode_stage.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int NUM_REGS = 32,
    parameter int XLEN     = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              instr_valid,
    input  wire logic [31:0]       instr,
    input  wire logic              stall,
    input  wire logic              flush,
    input  rv_decode_pkg::wb_req_t wb,
    output rv_decode_pkg::id_ex_t  id_ex
);

    rv_decode_pkg::inst_op_e  dec_op;
    rv_decode_pkg::imm_fmt_e  dec_fmt;
    rv_decode_pkg::reg_addr_t dec_rd;
    rv_decode_pkg::reg_addr_t dec_rs1;
    rv_decode_pkg::reg_addr_t dec_rs2;
    logic                     dec_illegal;
    logic [31:0]              imm;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;
    rv_decode_pkg::id_ex_t    id_ex_next;

    instruction_decoder u_decoder (
        .instr   (instr),
        .op      (dec_op),
        .fmt     (dec_fmt),
        .rd      (dec_rd),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .illegal (dec_illegal)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .fmt   (dec_fmt),
        .imm   (imm)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS),
        .XLEN     (XLEN)
    ) u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .rs1_addr (dec_rs1),
        .rs2_addr (dec_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        id_ex_next.valid    = instr_valid;
        id_ex_next.illegal  = instr_valid && dec_illegal;  // A bubble is never reported illegal
        id_ex_next.op       = dec_op;
        id_ex_next.rd       = dec_rd;
        id_ex_next.rs1      = dec_rs1;
        id_ex_next.rs2      = dec_rs2;
        id_ex_next.imm      = imm;
        id_ex_next.rs1_data = rs1_data;
        id_ex_next.rs2_data = rs2_data;
    end

    // Flush beats stall, and a stalled word is dropped until upstream presents it again
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (flush) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire logic [31:0]        instr,
    input  rv_decode_pkg::imm_fmt_e fmt,
    output logic [31:0]             imm
);

    logic sign;

    assign sign = instr[31];  // Every format takes its sign from bit 31

    always_comb begin
        case (fmt)
            rv_decode_pkg::FMT_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            rv_decode_pkg::FMT_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            rv_decode_pkg::FMT_B: begin
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            rv_decode_pkg::FMT_U: begin
                imm = {instr[31:12], 12'd0};
            end
            rv_decode_pkg::FMT_J: begin
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/instruction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
    input  wire logic [31:0]              instr,
    output rv_decode_pkg::inst_op_e       op,
    output rv_decode_pkg::imm_fmt_e       fmt,
    output rv_decode_pkg::reg_addr_t      rd,
    output rv_decode_pkg::reg_addr_t      rs1,
    output rv_decode_pkg::reg_addr_t      rs2,
    output logic                          illegal
);

    rv_decode_pkg::major_opcode_e opcode;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic [11:0]                  funct12;
    logic                         use_rd;
    logic                         use_rs1;
    logic                         use_rs2;
    logic                         f7_zero;
    logic                         f7_alt;

    assign opcode  = rv_decode_pkg::major_opcode_e'(instr[6:2]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];
    assign f7_zero = (funct7 == rv_decode_pkg::FUNCT7_ZERO);
    assign f7_alt  = (funct7 == rv_decode_pkg::FUNCT7_ALT);

    always_comb begin
        op      = rv_decode_pkg::OP_ILLEGAL;
        fmt     = rv_decode_pkg::FMT_R;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;

        if (instr[1:0] == 2'b11) begin  // Compressed space is not supported
            case (opcode)
                rv_decode_pkg::OPC_LUI: begin
                    op     = rv_decode_pkg::OP_LUI;
                    fmt    = rv_decode_pkg::FMT_U;
                    use_rd = 1'b1;
                end
                rv_decode_pkg::OPC_AUIPC: begin
                    op     = rv_decode_pkg::OP_AUIPC;
                    fmt    = rv_decode_pkg::FMT_U;
                    use_rd = 1'b1;
                end
                rv_decode_pkg::OPC_JAL: begin
                    op     = rv_decode_pkg::OP_JAL;
                    fmt    = rv_decode_pkg::FMT_J;
                    use_rd = 1'b1;
                end
                rv_decode_pkg::OPC_JALR: begin
                    if (funct3 == 3'b000) op = rv_decode_pkg::OP_JALR;
                    fmt     = rv_decode_pkg::FMT_I;
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end
                rv_decode_pkg::OPC_BRANCH: begin
                    case (funct3)
                        3'b000:  op = rv_decode_pkg::OP_BEQ;
                        3'b001:  op = rv_decode_pkg::OP_BNE;
                        3'b100:  op = rv_decode_pkg::OP_BLT;
                        3'b101:  op = rv_decode_pkg::OP_BGE;
                        3'b110:  op = rv_decode_pkg::OP_BLTU;
                        3'b111:  op = rv_decode_pkg::OP_BGEU;
                        default: op = rv_decode_pkg::OP_ILLEGAL;
                    endcase
                    fmt     = rv_decode_pkg::FMT_B;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                rv_decode_pkg::OPC_LOAD: begin
                    case (funct3)
                        3'b000:  op = rv_decode_pkg::OP_LB;
                        3'b001:  op = rv_decode_pkg::OP_LH;
                        3'b010:  op = rv_decode_pkg::OP_LW;
                        3'b100:  op = rv_decode_pkg::OP_LBU;
                        3'b101:  op = rv_decode_pkg::OP_LHU;
                        default: op = rv_decode_pkg::OP_ILLEGAL;
                    endcase
                    fmt     = rv_decode_pkg::FMT_I;
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end
                rv_decode_pkg::OPC_STORE: begin
                    case (funct3)
                        3'b000:  op = rv_decode_pkg::OP_SB;
                        3'b001:  op = rv_decode_pkg::OP_SH;
                        3'b010:  op = rv_decode_pkg::OP_SW;
                        default: op = rv_decode_pkg::OP_ILLEGAL;
                    endcase
                    fmt     = rv_decode_pkg::FMT_S;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                rv_decode_pkg::OPC_OP_IMM: begin
                    case (funct3)
                        3'b000: op = rv_decode_pkg::OP_ADDI;
                        3'b010: op = rv_decode_pkg::OP_SLTI;
                        3'b011: op = rv_decode_pkg::OP_SLTIU;
                        3'b100: op = rv_decode_pkg::OP_XORI;
                        3'b110: op = rv_decode_pkg::OP_ORI;
                        3'b111: op = rv_decode_pkg::OP_ANDI;
                        3'b001: if (f7_zero) op = rv_decode_pkg::OP_SLLI;
                        default: begin
                            if (f7_zero) op = rv_decode_pkg::OP_SRLI;
                            else if (f7_alt) op = rv_decode_pkg::OP_SRAI;
                        end
                    endcase
                    fmt     = rv_decode_pkg::FMT_I;
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                end
                rv_decode_pkg::OPC_OP: begin
                    if (f7_zero) begin
                        case (funct3)
                            3'b000:  op = rv_decode_pkg::OP_ADD;
                            3'b001:  op = rv_decode_pkg::OP_SLL;
                            3'b010:  op = rv_decode_pkg::OP_SLT;
                            3'b011:  op = rv_decode_pkg::OP_SLTU;
                            3'b100:  op = rv_decode_pkg::OP_XOR;
                            3'b101:  op = rv_decode_pkg::OP_SRL;
                            3'b110:  op = rv_decode_pkg::OP_OR;
                            default: op = rv_decode_pkg::OP_AND;
                        endcase
                    end else if (f7_alt && funct3 == 3'b000) begin
                        op = rv_decode_pkg::OP_SUB;
                    end else if (f7_alt && funct3 == 3'b101) begin
                        op = rv_decode_pkg::OP_SRA;
                    end
                    use_rd  = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                rv_decode_pkg::OPC_SYSTEM: begin
                    case (funct3)
                        3'b000: begin
                            case (funct12)
                                rv_decode_pkg::F12_ECALL:  op = rv_decode_pkg::OP_ECALL;
                                rv_decode_pkg::F12_EBREAK: op = rv_decode_pkg::OP_EBREAK;
                                rv_decode_pkg::F12_MRET:   op = rv_decode_pkg::OP_MRET;
                                rv_decode_pkg::F12_SRET:   op = rv_decode_pkg::OP_SRET;
                                rv_decode_pkg::F12_WFI:    op = rv_decode_pkg::OP_WFI;
                                default:                   op = rv_decode_pkg::OP_ILLEGAL;
                            endcase
                        end
                        3'b001:  op = rv_decode_pkg::OP_CSRRW;
                        3'b010:  op = rv_decode_pkg::OP_CSRRS;
                        3'b011:  op = rv_decode_pkg::OP_CSRRC;
                        3'b101:  op = rv_decode_pkg::OP_CSRRWI;
                        3'b110:  op = rv_decode_pkg::OP_CSRRSI;
                        3'b111:  op = rv_decode_pkg::OP_CSRRCI;
                        default: op = rv_decode_pkg::OP_ILLEGAL;
                    endcase
                    if (funct3 != 3'b000) begin
                        fmt     = rv_decode_pkg::FMT_I;  // CSR address sits in the I field
                        use_rd  = 1'b1;
                        use_rs1 = 1'b1;  // Carries zimm for the immediate CSR forms
                    end
                end
                default: op = rv_decode_pkg::OP_ILLEGAL;
            endcase
        end

        if (op == rv_decode_pkg::OP_ILLEGAL) begin
            fmt     = rv_decode_pkg::FMT_R;
            use_rd  = 1'b0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    assign rd      = use_rd  ? instr[11:7]  : 5'd0;
    assign rs1     = use_rs1 ? instr[19:15] : 5'd0;
    assign rs2     = use_rs2 ? instr[24:20] : 5'd0;
    assign illegal = (op == rv_decode_pkg::OP_ILLEGAL);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32,
    parameter int XLEN     = 32
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  rv_decode_pkg::wb_req_t  wb,
    input  rv_decode_pkg::reg_addr_t rs1_addr,
    input  rv_decode_pkg::reg_addr_t rs2_addr,
    output logic [XLEN-1:0]         rs1_data,
    output logic [XLEN-1:0]         rs2_data
);

    logic [XLEN-1:0] regs [0:NUM_REGS-1];
    logic            wr_live;
    logic            fwd_rs1;
    logic            fwd_rs2;

    assign wr_live = wb.en && (wb.addr != 5'd0);  // Writes to x0 never land

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb.addr] <= wb.data;
        end
    end

    assign fwd_rs1 = wr_live && (wb.addr == rs1_addr);
    assign fwd_rs2 = wr_live && (wb.addr == rs2_addr);

    always_comb begin
        if (fwd_rs1) begin
            rs1_data = wb.data;  // Same cycle write wins over the stored value
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (fwd_rs2) begin
            rs2_data = wb.data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } major_opcode_e;

    // Zero is the illegal code so a cleared pipeline register holds no real operation
    typedef enum logic [5:0] {
        OP_ILLEGAL = 6'd0,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_OR, OP_AND, OP_SRL, OP_SRA,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_CSRRW, OP_CSRRS, OP_CSRRC,
        OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
        OP_ECALL, OP_EBREAK, OP_MRET, OP_SRET, OP_WFI,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
    } inst_op_e;

    typedef enum logic [2:0] {
        FMT_R = 3'd0,  // No immediate
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_B = 3'd3,
        FMT_U = 3'd4,
        FMT_J = 3'd5
    } imm_fmt_e;

    typedef logic [4:0] reg_addr_t;

    typedef struct packed {
        logic        en;
        reg_addr_t   addr;
        logic [31:0] data;
    } wb_req_t;

    typedef struct packed {
        logic        valid;
        logic        illegal;
        inst_op_e    op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
    } id_ex_t;

    localparam logic [6:0]  FUNCT7_ZERO = 7'b0000000;
    localparam logic [6:0]  FUNCT7_ALT  = 7'b0100000;  // Selects sub and the arithmetic shifts
    localparam logic [11:0] F12_ECALL   = 12'h000;
    localparam logic [11:0] F12_EBREAK  = 12'h001;
    localparam logic [11:0] F12_SRET    = 12'h102;
    localparam logic [11:0] F12_WFI     = 12'h105;
    localparam logic [11:0] F12_MRET    = 12'h302;

endpackage

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;  // Released on an edge like any other synchronous input
    end

endmodule

`default_nettype wire

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    localparam int TIMEOUT_CYCLES = 4000;  // Directed tests need well under 2500 cycles
    localparam rv_decode_pkg::wb_req_t NO_WB = '0;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    logic [31:0]            instr;
    logic                   stall;
    logic                   flush;
    rv_decode_pkg::wb_req_t wb;
    rv_decode_pkg::id_ex_t  id_ex;
    logic [31:0]            shadow [0:31];
    int                     cycles;
    int                     checks;
    int                     errors;

    tb_clock u_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    decode_stage #(
        .NUM_REGS (32),
        .XLEN     (32)
    ) u_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .flush       (flush),
        .wb          (wb),
        .id_ex       (id_ex)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ISA match value of each instruction, the bits that its encoding fixes
    function automatic logic [31:0] match_bits(rv_decode_pkg::inst_op_e op);
        case (op)
            rv_decode_pkg::OP_BEQ:    return 32'h0000_0063;
            rv_decode_pkg::OP_BNE:    return 32'h0000_1063;
            rv_decode_pkg::OP_BLT:    return 32'h0000_4063;
            rv_decode_pkg::OP_BGE:    return 32'h0000_5063;
            rv_decode_pkg::OP_BLTU:   return 32'h0000_6063;
            rv_decode_pkg::OP_BGEU:   return 32'h0000_7063;
            rv_decode_pkg::OP_ADDI:   return 32'h0000_0013;
            rv_decode_pkg::OP_SLTI:   return 32'h0000_2013;
            rv_decode_pkg::OP_SLTIU:  return 32'h0000_3013;
            rv_decode_pkg::OP_XORI:   return 32'h0000_4013;
            rv_decode_pkg::OP_ORI:    return 32'h0000_6013;
            rv_decode_pkg::OP_ANDI:   return 32'h0000_7013;
            rv_decode_pkg::OP_SLLI:   return 32'h0000_1013;
            rv_decode_pkg::OP_SRLI:   return 32'h0000_5013;
            rv_decode_pkg::OP_SRAI:   return 32'h4000_5013;
            rv_decode_pkg::OP_ADD:    return 32'h0000_0033;
            rv_decode_pkg::OP_SUB:    return 32'h4000_0033;
            rv_decode_pkg::OP_SLL:    return 32'h0000_1033;
            rv_decode_pkg::OP_SLT:    return 32'h0000_2033;
            rv_decode_pkg::OP_SLTU:   return 32'h0000_3033;
            rv_decode_pkg::OP_XOR:    return 32'h0000_4033;
            rv_decode_pkg::OP_OR:     return 32'h0000_6033;
            rv_decode_pkg::OP_AND:    return 32'h0000_7033;
            rv_decode_pkg::OP_SRL:    return 32'h0000_5033;
            rv_decode_pkg::OP_SRA:    return 32'h4000_5033;
            rv_decode_pkg::OP_LB:     return 32'h0000_0003;
            rv_decode_pkg::OP_LH:     return 32'h0000_1003;
            rv_decode_pkg::OP_LW:     return 32'h0000_2003;
            rv_decode_pkg::OP_LBU:    return 32'h0000_4003;
            rv_decode_pkg::OP_LHU:    return 32'h0000_5003;
            rv_decode_pkg::OP_SB:     return 32'h0000_0023;
            rv_decode_pkg::OP_SH:     return 32'h0000_1023;
            rv_decode_pkg::OP_SW:     return 32'h0000_2023;
            rv_decode_pkg::OP_CSRRW:  return 32'h0000_1073;
            rv_decode_pkg::OP_CSRRS:  return 32'h0000_2073;
            rv_decode_pkg::OP_CSRRC:  return 32'h0000_3073;
            rv_decode_pkg::OP_CSRRWI: return 32'h0000_5073;
            rv_decode_pkg::OP_CSRRSI: return 32'h0000_6073;
            rv_decode_pkg::OP_CSRRCI: return 32'h0000_7073;
            rv_decode_pkg::OP_ECALL:  return 32'h0000_0073;
            rv_decode_pkg::OP_EBREAK: return 32'h0010_0073;
            rv_decode_pkg::OP_MRET:   return 32'h3020_0073;
            rv_decode_pkg::OP_SRET:   return 32'h1020_0073;
            rv_decode_pkg::OP_WFI:    return 32'h1050_0073;
            rv_decode_pkg::OP_JAL:    return 32'h0000_006f;
            rv_decode_pkg::OP_JALR:   return 32'h0000_0067;
            rv_decode_pkg::OP_LUI:    return 32'h0000_0037;
            rv_decode_pkg::OP_AUIPC:  return 32'h0000_0017;
            default:                  return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [31:0] fixed_mask(logic [31:0] m);
        logic [2:0] f3;
        f3 = m[14:12];
        case (m[6:0])
            7'h37, 7'h17, 7'h6f: return 32'h0000_007f;
            7'h33: return 32'hfe00_707f;
            7'h13: return (f3 == 3'd1 || f3 == 3'd5) ? 32'hfe00_707f : 32'h0000_707f;
            7'h73: return (f3 == 3'd0) ? 32'hfff0_707f : 32'h0000_707f;
            default: return 32'h0000_707f;
        endcase
    endfunction

    function automatic logic [31:0] sext(logic [31:0] v, int bits);
        logic [31:0] top;
        top = 32'd1 << (bits - 1);
        return (v ^ top) - top;  // Flip the sign bit and take its weight back off
    endfunction

    function automatic rv_decode_pkg::id_ex_t expect_decode(logic [31:0] w);
        rv_decode_pkg::id_ex_t   e;
        rv_decode_pkg::inst_op_e op;
        logic [31:0]             m;
        e = '0;
        e.valid = 1'b1;
        e.illegal = 1'b1;
        for (int i = 1; i < 64; i++) begin
            op = rv_decode_pkg::inst_op_e'(6'(i));
            m  = match_bits(op);
            if (m != 32'd0 && (w & fixed_mask(m)) == m) begin
                e.op      = op;
                e.illegal = 1'b0;
            end
        end
        if (e.illegal) return e;
        case (w[6:0])
            7'h37, 7'h17: begin
                e.rd  = w[11:7];
                e.imm = {w[31:12], 12'h000};
            end
            7'h6f: begin
                e.rd  = w[11:7];
                e.imm = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            end
            7'h63: begin
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
                e.imm = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            end
            7'h23: begin
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
                e.imm = sext(32'({w[31:25], w[11:7]}), 12);
            end
            7'h33: begin
                e.rd  = w[11:7];
                e.rs1 = w[19:15];
                e.rs2 = w[24:20];
            end
            default: begin
                if (!(w[6:0] == 7'h73 && w[14:12] == 3'b000)) begin  // Privileged ops carry no fields
                    e.rd  = w[11:7];
                    e.rs1 = w[19:15];
                    e.imm = sext(32'(w[31:20]), 12);
                end
            end
        endcase
        return e;
    endfunction

    function automatic logic [31:0] read_model(rv_decode_pkg::reg_addr_t a,
                                               rv_decode_pkg::wb_req_t w);
        if (a == 5'd0) return 32'd0;
        if (w.en && w.addr == a) return w.data;
        return shadow[a];
    endfunction

    function automatic rv_decode_pkg::id_ex_t expect_with_data(logic [31:0] word,
                                                              rv_decode_pkg::wb_req_t w);
        rv_decode_pkg::id_ex_t e;
        e = expect_decode(word);
        e.rs1_data = read_model(e.rs1, w);
        e.rs2_data = read_model(e.rs2, w);
        return e;
    endfunction

    function automatic rv_decode_pkg::inst_op_e random_op();
        rv_decode_pkg::inst_op_e op;
        do begin
            op = rv_decode_pkg::inst_op_e'(6'($urandom_range(1, 63)));
        end while (match_bits(op) == 32'd0);
        return op;
    endfunction

    function automatic logic [31:0] make_word(rv_decode_pkg::inst_op_e op);
        logic [31:0] m;
        m = match_bits(op);
        return ($urandom() & ~fixed_mask(m)) | m;
    endfunction

    function automatic logic [31:0] add_word(int a, int b);
        return {7'h00, 5'(b), 5'(a), 3'b000, 5'($urandom()), 7'h33};
    endfunction

    task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic compare_out(rv_decode_pkg::id_ex_t want);
        check_field("id_ex.valid", 32'(id_ex.valid), 32'(want.valid));
        check_field("id_ex.illegal", 32'(id_ex.illegal), 32'(want.illegal));
        check_field("id_ex.op", 32'(id_ex.op), 32'(want.op));
        check_field("id_ex.rd", 32'(id_ex.rd), 32'(want.rd));
        check_field("id_ex.rs1", 32'(id_ex.rs1), 32'(want.rs1));
        check_field("id_ex.rs2", 32'(id_ex.rs2), 32'(want.rs2));
        check_field("id_ex.imm", id_ex.imm, want.imm);
        check_field("id_ex.rs1_data", id_ex.rs1_data, want.rs1_data);
        check_field("id_ex.rs2_data", id_ex.rs2_data, want.rs2_data);
    endtask

    task automatic present(logic [31:0] word, logic valid, logic stl, logic fl,
                           rv_decode_pkg::wb_req_t w);
        @(posedge clk);
        instr       <= word;
        instr_valid <= valid;
        stall       <= stl;
        flush       <= fl;
        wb          <= w;
    endtask

    task automatic note_write(rv_decode_pkg::wb_req_t w);
        if (w.en && w.addr != 5'd0) begin
            shadow[w.addr] = w.data;
        end
    endtask

    task automatic decode_and_check(logic [31:0] word, rv_decode_pkg::wb_req_t w);
        rv_decode_pkg::id_ex_t want;
        want = expect_with_data(word, w);
        present(word, 1'b1, 1'b0, 1'b0, w);
        note_write(w);
        present(word, 1'b0, 1'b0, 1'b0, NO_WB);
        @(negedge clk);
        compare_out(want);
    endtask

    task automatic test_reset();
        rv_decode_pkg::id_ex_t  cleared;
        rv_decode_pkg::wb_req_t w;
        cleared = '0;
        w = '{en: 1'b1, addr: 5'd5, data: $urandom()};
        present(add_word(5, 6), 1'b1, 1'b0, 1'b0, w);  // Reset beats the word and the write
        present(32'd0, 1'b0, 1'b0, 1'b0, NO_WB);
        @(negedge clk);
        compare_out(cleared);
        while (rst) begin
            @(posedge clk);
        end
        for (int a = 0; a < 32; a++) begin
            decode_and_check(add_word(a, 31 - a), NO_WB);
        end
    endtask

    task automatic test_register_file();
        rv_decode_pkg::wb_req_t w;
        for (int a = 1; a < 32; a++) begin
            w = '{en: 1'b1, addr: 5'(a), data: $urandom()};
            decode_and_check(add_word(a, (a + 7) % 32), w);  // rs1 takes the forwarded write
        end
        w = '{en: 1'b1, addr: 5'd0, data: 32'hdead_beef};
        decode_and_check(add_word(0, 0), w);
        decode_and_check(add_word(0, 0), NO_WB);
        for (int a = 1; a < 32; a++) begin
            decode_and_check(add_word(a, 32 - a), NO_WB);
        end
    endtask

    task automatic test_ops_and_immediates();
        rv_decode_pkg::inst_op_e op;
        rv_decode_pkg::id_ex_t   model;
        logic [31:0]             word;
        logic [31:0]             mk;
        for (int i = 1; i < 64; i++) begin
            op = rv_decode_pkg::inst_op_e'(6'(i));
            if (match_bits(op) == 32'd0) continue;
            mk = fixed_mask(match_bits(op));
            for (int rep = 0; rep < 4; rep++) begin
                word = make_word(op);
                if (!mk[31]) word[31] = rep[0];  // Alternate the immediate sign
                model = expect_decode(word);
                if (model.op != op) begin
                    errors++;
                    $display("Reference model decoded %h as op %0d, test expected op %0d",
                             word, model.op, op);
                end
                decode_and_check(word, NO_WB);
            end
        end
    endtask

    task automatic test_illegal();
        logic [31:0] bad [16];
        bad = '{32'h0000_2063, 32'h0000_3063, 32'h0000_3003, 32'h0000_7003,
                32'h0000_3023, 32'h0000_4073, 32'h0000_1067, 32'h0020_0073,
                32'h0200_0033, 32'h4000_1033, 32'h4000_1013, 32'h0200_5013,
                32'h0000_000b, 32'h0000_0011, 32'h0000_0000, 32'h4000_6033};
        foreach (bad[k]) begin
            decode_and_check(bad[k], NO_WB);
            check_field("id_ex.illegal", 32'(id_ex.illegal), 32'd1);
            check_field("id_ex.op", 32'(id_ex.op), 32'(rv_decode_pkg::OP_ILLEGAL));
        end
    endtask

    task automatic test_stream_stall_flush();
        logic [31:0]           words [8];
        rv_decode_pkg::id_ex_t wants [8];
        for (int k = 0; k < 8; k++) begin
            words[k] = make_word(random_op());
            wants[k] = expect_with_data(words[k], NO_WB);
        end
        for (int k = 0; k <= 8; k++) begin
            if (k < 8) begin
                present(words[k], 1'b1, 1'b0, 1'b0, NO_WB);
            end else begin
                present(32'd0, 1'b0, 1'b1, 1'b0, NO_WB);  // Stall holds the last word
            end
            if (k > 0) begin
                @(negedge clk);
                compare_out(wants[k - 1]);
            end
        end
        repeat (3) begin
            present($urandom(), 1'b1, 1'b1, 1'b0, NO_WB);
            @(negedge clk);
            compare_out(wants[7]);
        end
        present($urandom(), 1'b1, 1'b1, 1'b1, NO_WB);
        @(negedge clk);
        compare_out(wants[7]);
        present(32'd0, 1'b0, 1'b0, 1'b0, NO_WB);
        @(negedge clk);
        check_field("id_ex.valid", 32'(id_ex.valid), 32'd0);
        present(words[0], 1'b1, 1'b0, 1'b0, NO_WB);
        present(words[1], 1'b1, 1'b0, 1'b1, NO_WB);  // Flush wins over a valid word
        @(negedge clk);
        compare_out(wants[0]);
        present(32'd0, 1'b0, 1'b0, 1'b0, NO_WB);
        @(negedge clk);
        check_field("id_ex.valid", 32'(id_ex.valid), 32'd0);
    endtask

    initial begin
        void'($urandom(86161));
        instr       = 32'd0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb          = NO_WB;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = 32'd0;
        end
        test_reset();
        test_register_file();
        test_ops_and_immediates();
        test_illegal();
        test_stream_stall_flush();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
